/* dv/tb_top.sv */
module tb_top import bmu_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   logic                  clk;
   logic                  rst_n;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic [line_adr_w-1:0] wb_adr;
   line_t                 wb_rdata;
   logic                  wb_ack;
   logic                  halted;
   logic                  illegal;
   reg_idx_t              dbg_addr;
   word_t                 dbg_data;

   // memory image, program and expected register state
   line_t mem [64];
   word_t prog [$];
   word_t exp_regs [nregs];
   // ack delay of each bus cycle by cycle count
   int    delay_tab [64];
   int    seed = 32'h4955;
   string test_name;

   // memory model state
   int    bus_cnt;
   int    wait_cnt;
   bit    bus_open;

   bmu_core_top u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_adr   (wb_adr),
      .wb_rdata (wb_rdata),
      .wb_ack   (wb_ack),
      .halted   (halted),
      .illegal  (illegal),
      .dbg_addr (dbg_addr),
      .dbg_data (dbg_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_sim();
      $display("sim failed");
      $fatal(1, "stopped at the first error");
   endtask

   // wishbone classic read slave driven 1 ns after each edge
   initial begin
      wb_ack   = 1'b0;
      wb_rdata = '0;
      bus_cnt  = 0;
      wait_cnt = 0;
      bus_open = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (!rst_n) begin
            wb_ack   = 1'b0;
            wait_cnt = 0;
            bus_open = 1'b0;
         end else if (wb_stb !== wb_cyc) begin
            $display("wishbone stb does not follow cyc");
            stop_sim();
         end else if (wb_ack) begin
            // single beat and the master drops cyc on the ack edge
            wb_ack = 1'b0;
         end else if (wb_cyc && wb_stb) begin
            bus_open = 1'b1;
            if (wait_cnt >= delay_tab[bus_cnt % 64]) begin
               wb_rdata = mem[wb_adr[5:0]];
               wb_ack   = 1'b1;
               wait_cnt = 0;
               bus_open = 1'b0;
               bus_cnt++;
            end else begin
               wait_cnt++;
            end
         end else if (bus_open) begin
            $display("wishbone cyc dropped before the memory acked");
            stop_sim();
         end
      end
   end

   task automatic check_word(string what, word_t exp, word_t act);
      if (act !== exp) begin
         $display("[ERROR] %s %s expected %h actual %h", test_name, what, exp, act);
         stop_sim();
      end
   endtask

   task automatic check_flag(string what, logic exp, logic act);
      if (act !== exp) begin
         $display("[ERROR] %s %s expected %b actual %b", test_name, what, exp, act);
         stop_sim();
      end
   endtask

   // reference result of each operation
   function automatic word_t model_op(bmu_op_e op, word_t a, word_t b);
      word_t r;
      int    n;
      int    k;
      n = int'(b[4:0]);
      r = '0;
      k = 0;
      case (op)
         op_add:    r = a + b;
         op_sub:    r = a - b;
         op_xor:    r = a ^ b;
         op_or:     r = a | b;
         op_and:    r = a & b;
         op_sll:    r = a << n;
         op_srl:    r = a >> n;
         op_sra:    r = word_t'($signed(a) >>> n);
         op_lui:    r = b;
         op_andn:   r = a & ~b;
         op_orn:    r = a | ~b;
         op_xnor:   r = a ^ ~b;
         op_clz: begin
            while (k < 32 && !a[31-k]) k++;
            r = word_t'(k);
         end
         op_ctz: begin
            while (k < 32 && !a[k]) k++;
            r = word_t'(k);
         end
         op_cpop:   r = word_t'($countones(a));
         // flip the sign bit then subtract its weight
         op_sext_b: r = ({24'b0, a[7:0]} ^ 32'h80) - 32'h80;
         op_sext_h: r = ({16'b0, a[15:0]} ^ 32'h8000) - 32'h8000;
         op_zext_h: r = a & 32'h0000_ffff;
         op_rol: begin
            r = a;
            for (k = 0; k < n; k++) r = {r[30:0], r[31]};
         end
         op_ror: begin
            r = a;
            for (k = 0; k < n; k++) r = {r[0], r[31:1]};
         end
         op_rev8: begin
            for (k = 0; k < 4; k++) r[8*k +: 8] = a[8*(3-k) +: 8];
         end
         op_orc_b: begin
            for (k = 0; k < 4; k++) r[8*k +: 8] = (a[8*k +: 8] != 8'h00) ? 8'hff : 8'h00;
         end
         op_bclr:   r = a & ~(32'h1 << n);
         op_bset:   r = a | (32'h1 << n);
         op_binv:   r = a ^ (32'h1 << n);
         op_bext:   r = (a >> n) & 32'h1;
         op_sh1add: r = a * 2 + b;
         op_sh2add: r = a * 4 + b;
         op_sh3add: r = a * 8 + b;
         default:   r = '0;
      endcase
      return r;
   endfunction

   task automatic set_expected(reg_idx_t rd, word_t val);
      if (rd != 5'd0) exp_regs[rd] = val;
   endtask

   task automatic clear_program();
      int k;
      prog.delete();
      for (k = 0; k < nregs; k++) exp_regs[k] = '0;
   endtask

   // instruction words the model does not track
   task automatic raw_insn(word_t w);
      prog.push_back(w);
   endtask

   task automatic r_insn(bmu_op_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
      logic [9:0] f;
      f = '0;
      // funct7 then funct3
      case (op)
         op_add:    f = {7'b0000000, 3'b000};
         op_sub:    f = {7'b0100000, 3'b000};
         op_xor:    f = {7'b0000000, 3'b100};
         op_or:     f = {7'b0000000, 3'b110};
         op_and:    f = {7'b0000000, 3'b111};
         op_sll:    f = {7'b0000000, 3'b001};
         op_srl:    f = {7'b0000000, 3'b101};
         op_sra:    f = {7'b0100000, 3'b101};
         op_andn:   f = {7'b0100000, 3'b111};
         op_orn:    f = {7'b0100000, 3'b110};
         op_xnor:   f = {7'b0100000, 3'b100};
         op_rol:    f = {7'b0110000, 3'b001};
         op_ror:    f = {7'b0110000, 3'b101};
         op_bclr:   f = {7'b0100100, 3'b001};
         op_bset:   f = {7'b0010100, 3'b001};
         op_binv:   f = {7'b0110100, 3'b001};
         op_bext:   f = {7'b0100100, 3'b101};
         op_sh1add: f = {7'b0010000, 3'b010};
         op_sh2add: f = {7'b0010000, 3'b100};
         op_sh3add: f = {7'b0010000, 3'b110};
         default: begin
            $display("no register form for operation %s", op.name());
            stop_sim();
         end
      endcase
      prog.push_back({f[9:3], rs2, rs1, f[2:0], rd, opc_op});
      set_expected(rd, model_op(op, exp_regs[rs1], exp_regs[rs2]));
   endtask

   // shift forms only keep imm[4:0] under their funct7
   task automatic imm_insn(bmu_op_e op, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
      logic [11:0] v;
      logic [2:0]  f3;
      v  = imm;
      f3 = 3'b000;
      case (op)
         op_add:  f3 = 3'b000;
         op_xor:  f3 = 3'b100;
         op_or:   f3 = 3'b110;
         op_and:  f3 = 3'b111;
         op_sll:  {v, f3} = {7'b0000000, imm[4:0], 3'b001};
         op_srl:  {v, f3} = {7'b0000000, imm[4:0], 3'b101};
         op_sra:  {v, f3} = {7'b0100000, imm[4:0], 3'b101};
         op_ror:  {v, f3} = {7'b0110000, imm[4:0], 3'b101};
         op_bclr: {v, f3} = {7'b0100100, imm[4:0], 3'b001};
         op_bset: {v, f3} = {7'b0010100, imm[4:0], 3'b001};
         op_binv: {v, f3} = {7'b0110100, imm[4:0], 3'b001};
         op_bext: {v, f3} = {7'b0100100, imm[4:0], 3'b101};
         default: begin
            $display("no immediate form for operation %s", op.name());
            stop_sim();
         end
      endcase
      prog.push_back({v, rs1, f3, rd, opc_op_imm});
      set_expected(rd, model_op(op, exp_regs[rs1], {{20{v[11]}}, v}));
   endtask

   // zbb single source forms
   task automatic unary_insn(bmu_op_e op, reg_idx_t rd, reg_idx_t rs1);
      word_t w;
      w = '0;
      case (op)
         op_clz:    w = {12'h600, rs1, 3'b001, rd, opc_op_imm};
         op_ctz:    w = {12'h601, rs1, 3'b001, rd, opc_op_imm};
         op_cpop:   w = {12'h602, rs1, 3'b001, rd, opc_op_imm};
         op_sext_b: w = {12'h604, rs1, 3'b001, rd, opc_op_imm};
         op_sext_h: w = {12'h605, rs1, 3'b001, rd, opc_op_imm};
         op_rev8:   w = {12'h698, rs1, 3'b101, rd, opc_op_imm};
         op_orc_b:  w = {12'h287, rs1, 3'b101, rd, opc_op_imm};
         op_zext_h: w = {7'b0000100, 5'd0, rs1, 3'b100, rd, opc_op};
         default: begin
            $display("no unary form for operation %s", op.name());
            stop_sim();
         end
      endcase
      prog.push_back(w);
      set_expected(rd, model_op(op, exp_regs[rs1], '0));
   endtask

   // lui then addi with the upper part rounded for the signed low part
   task automatic load_const(reg_idx_t rd, word_t v);
      word_t hi;
      hi = v + 32'h800;
      prog.push_back({hi[31:12], rd, opc_lui});
      set_expected(rd, model_op(op_lui, '0, {hi[31:12], 12'b0}));
      imm_insn(op_add, rd, rd, v[11:0]);
   endtask

   // one delay for all bus cycles or a fresh one per cycle
   task automatic fill_delays(bit per_cycle);
      int d;
      int k;
      d = $random(seed) & 3;
      for (k = 0; k < 64; k++) delay_tab[k] = per_cycle ? ($random(seed) & 3) : d;
   endtask

   task automatic load_memory();
      int l;
      int w;
      // filler words carry their own byte address
      for (l = 0; l < 64; l++) begin
         for (w = 0; w < 4; w++) mem[l][w*32 +: 32] = 32'hf00f_0000 | word_t'(l * 16 + w * 4);
      end
      for (l = 0; l < prog.size(); l++) mem[l/4][(l%4)*32 +: 32] = prog[l];
   endtask

   task automatic reset_dut();
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
   endtask

   task automatic wait_halted();
      int n;
      bit done;
      done = 1'b0;
      for (n = 0; n < 4000 && !done; n++) begin
         @(negedge clk);
         done = halted;
      end
      if (!done) begin
         $display("program of test %s did not halt within 4000 cycles", test_name);
         stop_sim();
      end
   endtask

   task automatic run_program();
      load_memory();
      reset_dut();
      wait_halted();
   endtask

   // debug port read mid cycle
   task automatic check_regs();
      int i;
      for (i = 0; i < nregs; i++) begin
         @(posedge clk);
         #1;
         dbg_addr = reg_idx_t'(i);
         @(negedge clk);
         check_word($sformatf("x%0d", i), exp_regs[i], dbg_data);
      end
   endtask

   task automatic check_status(logic exp_illegal);
      check_flag("halted", 1'b1, halted);
      check_flag("illegal", exp_illegal, illegal);
   endtask

   task automatic test_reset();
      test_name = "reset";
      fill_delays(1'b0);
      clear_program();
      raw_insn(ebreak_insn);
      load_memory();
      reset_dut();
      // no edge yet since release
      @(negedge clk);
      check_flag("halted", 1'b0, halted);
      check_flag("illegal", 1'b0, illegal);
      check_flag("wb_cyc", 1'b0, wb_cyc);
      wait_halted();
      check_regs();
      check_status(1'b0);
   endtask

   task automatic test_base_ops();
      test_name = "base_ops";
      fill_delays(1'b0);
      clear_program();
      imm_insn(op_add, 5'd1, 5'd0, 12'h123);
      load_const(5'd2, 32'habcd_e7ff);
      r_insn(op_xor, 5'd3, 5'd1, 5'd2);
      r_insn(op_add, 5'd4, 5'd3, 5'd1);
      // write to x0 is dropped
      imm_insn(op_add, 5'd0, 5'd1, 12'h055);
      r_insn(op_add, 5'd5, 5'd0, 5'd4);
      imm_insn(op_add, 5'd6, 5'd0, 12'h800);
      raw_insn(ebreak_insn);
      run_program();
      check_regs();
      check_status(1'b0);
   endtask

   task automatic test_zbb();
      word_t v1;
      word_t v2;
      word_t v3;
      test_name = "zbb";
      fill_delays(1'b0);
      clear_program();
      v1 = $random(seed);
      v2 = $random(seed);
      v3 = $random(seed);
      load_const(5'd1, v1);
      load_const(5'd2, v2);
      load_const(5'd3, v3);
      // some zero bytes for orc.b
      load_const(5'd12, v3 & 32'h00ff_0f00);
      load_const(5'd20, v2 >> 13);
      unary_insn(op_clz, 5'd4, 5'd1);
      unary_insn(op_ctz, 5'd5, 5'd2);
      unary_insn(op_cpop, 5'd6, 5'd3);
      unary_insn(op_sext_b, 5'd7, 5'd1);
      unary_insn(op_sext_h, 5'd8, 5'd2);
      unary_insn(op_zext_h, 5'd9, 5'd3);
      unary_insn(op_rev8, 5'd10, 5'd1);
      unary_insn(op_orc_b, 5'd11, 5'd12);
      r_insn(op_andn, 5'd13, 5'd1, 5'd2);
      r_insn(op_orn, 5'd14, 5'd2, 5'd3);
      r_insn(op_xnor, 5'd15, 5'd1, 5'd3);
      // counts of a zero input saturate at 32
      unary_insn(op_clz, 5'd16, 5'd0);
      unary_insn(op_ctz, 5'd17, 5'd0);
      unary_insn(op_clz, 5'd21, 5'd20);
      unary_insn(op_sext_b, 5'd19, 5'd12);
      raw_insn(ebreak_insn);
      run_program();
      check_regs();
      check_status(1'b0);
   endtask

   task automatic test_rot_bit_shadd();
      test_name = "rot_bit_shadd";
      fill_delays(1'b0);
      clear_program();
      load_const(5'd1, $random(seed));
      load_const(5'd2, $random(seed));
      load_const(5'd3, $random(seed));
      r_insn(op_rol, 5'd4, 5'd1, 5'd2);
      r_insn(op_ror, 5'd5, 5'd1, 5'd2);
      imm_insn(op_ror, 5'd6, 5'd1, 12'd13);
      r_insn(op_bclr, 5'd7, 5'd1, 5'd2);
      r_insn(op_bset, 5'd8, 5'd1, 5'd3);
      r_insn(op_binv, 5'd9, 5'd2, 5'd3);
      r_insn(op_bext, 5'd10, 5'd1, 5'd3);
      imm_insn(op_bclr, 5'd11, 5'd1, 12'd31);
      imm_insn(op_bset, 5'd12, 5'd2, 12'd7);
      imm_insn(op_binv, 5'd13, 5'd3, 12'd0);
      imm_insn(op_bext, 5'd14, 5'd1, 12'd5);
      r_insn(op_sh1add, 5'd15, 5'd1, 5'd2);
      r_insn(op_sh2add, 5'd16, 5'd2, 5'd3);
      r_insn(op_sh3add, 5'd17, 5'd3, 5'd1);
      // rotate by zero
      r_insn(op_rol, 5'd18, 5'd1, 5'd0);
      imm_insn(op_ror, 5'd19, 5'd2, 12'd0);
      raw_insn(ebreak_insn);
      run_program();
      check_regs();
      check_status(1'b0);
   endtask

   task automatic test_fetch_stall();
      int k;
      test_name = "fetch_stall";
      clear_program();
      // six lines of code
      load_const(5'd1, 32'h1234_5678);
      load_const(5'd2, $random(seed));
      load_const(5'd3, 32'hfedc_ba98);
      load_const(5'd4, 32'h0000_0013);
      r_insn(op_add, 5'd5, 5'd1, 5'd2);
      r_insn(op_sub, 5'd6, 5'd3, 5'd4);
      r_insn(op_sll, 5'd7, 5'd1, 5'd4);
      r_insn(op_srl, 5'd8, 5'd3, 5'd4);
      r_insn(op_sra, 5'd9, 5'd3, 5'd4);
      r_insn(op_or, 5'd10, 5'd5, 5'd6);
      r_insn(op_and, 5'd11, 5'd7, 5'd8);
      imm_insn(op_sll, 5'd12, 5'd1, 12'd4);
      imm_insn(op_srl, 5'd13, 5'd3, 12'd8);
      imm_insn(op_sra, 5'd14, 5'd3, 12'd31);
      imm_insn(op_xor, 5'd15, 5'd2, 12'hfff);
      imm_insn(op_or, 5'd16, 5'd1, 12'h0f0);
      imm_insn(op_and, 5'd17, 5'd3, 12'h7ff);
      raw_insn(ebreak_insn);
      // zero delay pass first
      for (k = 0; k < 64; k++) delay_tab[k] = 0;
      run_program();
      check_regs();
      check_status(1'b0);
      // same program with a fresh delay each bus cycle
      test_name = "fetch_stall_delayed";
      fill_delays(1'b1);
      run_program();
      check_regs();
      check_status(1'b0);
   endtask

   task automatic test_halting();
      test_name = "halt_illegal";
      fill_delays(1'b0);
      clear_program();
      imm_insn(op_add, 5'd1, 5'd0, 12'h007);
      // slti is not supported
      raw_insn({12'h005, 5'd0, 3'b010, 5'd2, opc_op_imm});
      raw_insn({12'h009, 5'd0, 3'b000, 5'd3, opc_op_imm});
      run_program();
      check_regs();
      check_status(1'b1);
      test_name = "halt_ebreak";
      clear_program();
      imm_insn(op_add, 5'd1, 5'd0, 12'h003);
      raw_insn(ebreak_insn);
      raw_insn({12'h001, 5'd0, 3'b000, 5'd4, opc_op_imm});
      run_program();
      check_regs();
      check_status(1'b0);
   endtask

   initial begin
      rst_n    = 1'b0;
      dbg_addr = '0;
      test_reset();
      test_base_ops();
      test_zbb();
      test_rot_bit_shadd();
      test_fetch_stall();
      test_halting();
      $display("sim passed");
      $finish;
   end

endmodule

/* hdl/bmu_alu.sv */
module bmu_alu import bmu_pkg::*; (
   input  bmu_op_e op,
   input  word_t   a,
   input  word_t   b,
   output word_t   result
);

   logic [4:0] shamt;

   // leading zeros, the highest set bit wins
   function automatic word_t count_lz(word_t v);
      word_t n;
      n = word_t'(xlen);
      for (int i = 0; i < xlen; i++) begin
         if (v[i]) n = word_t'(xlen - 1 - i);
      end
      return n;
   endfunction

   // trailing zeros, the lowest set bit wins
   function automatic word_t count_tz(word_t v);
      word_t n;
      n = word_t'(xlen);
      for (int i = xlen - 1; i >= 0; i--) begin
         if (v[i]) n = word_t'(i);
      end
      return n;
   endfunction

   function automatic word_t count_pop(word_t v);
      word_t n;
      n = '0;
      for (int i = 0; i < xlen; i++) begin
         n = n + word_t'(v[i]);
      end
      return n;
   endfunction

   // each byte becomes all ones if any bit set
   function automatic word_t or_combine(word_t v);
      word_t r;
      for (int i = 0; i < xlen / 8; i++) begin
         r[i*8 +: 8] = (|v[i*8 +: 8]) ? 8'hff : 8'h00;
      end
      return r;
   endfunction

   assign shamt = b[4:0];

   always_comb begin
      case (op)
         op_add:    result = a + b;
         op_sub:    result = a - b;
         op_xor:    result = a ^ b;
         op_or:     result = a | b;
         op_and:    result = a & b;
         op_sll:    result = a << shamt;
         op_srl:    result = a >> shamt;
         op_sra:    result = word_t'($signed(a) >>> shamt);
         // b already holds the shifted upper immediate
         op_lui:    result = b;
         op_andn:   result = a & ~b;
         op_orn:    result = a | ~b;
         op_xnor:   result = ~(a ^ b);
         op_clz:    result = count_lz(a);
         op_ctz:    result = count_tz(a);
         op_cpop:   result = count_pop(a);
         op_sext_b: result = {{24{a[7]}}, a[7:0]};
         op_sext_h: result = {{16{a[15]}}, a[15:0]};
         op_zext_h: result = {16'b0, a[15:0]};
         // shift by xlen gives zero, so shamt 0 rotates cleanly
         op_rol:    result = (a << shamt) | (a >> (xlen - int'(shamt)));
         op_ror:    result = (a >> shamt) | (a << (xlen - int'(shamt)));
         op_rev8:   result = {a[7:0], a[15:8], a[23:16], a[31:24]};
         op_orc_b:  result = or_combine(a);
         // single bit ops on a, bit picked by b
         op_bclr:   result = a & ~(word_t'(1) << shamt);
         op_bset:   result = a | (word_t'(1) << shamt);
         op_binv:   result = a ^ (word_t'(1) << shamt);
         op_bext:   result = {{(xlen-1){1'b0}}, a[shamt]};
         op_sh1add: result = (a << 1) + b;
         op_sh2add: result = (a << 2) + b;
         op_sh3add: result = (a << 3) + b;
         default:   result = '0;
      endcase
   end

endmodule

/* hdl/bmu_core_top.sv */
module bmu_core_top import bmu_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   output logic                  wb_cyc,
   output logic                  wb_stb,
   output logic [line_adr_w-1:0] wb_adr,
   input  line_t                 wb_rdata,
   input  logic                  wb_ack,
   output logic                  halted,
   output logic                  illegal,
   input  reg_idx_t              dbg_addr,
   output word_t                 dbg_data
);

   word_t    insn;
   bmu_op_e  op;
   reg_idx_t rd;
   reg_idx_t rs1;
   reg_idx_t rs2;
   word_t    imm;
   logic     use_imm;
   logic     halt_req;
   logic     illegal_req;
   logic     reg_we;
   word_t    rdata_a;
   word_t    rdata_b;
   word_t    opb;
   word_t    result;

   fetch_if fif ();

   core_ctrl u_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .fif         (fif.ctrl),
      .insn        (insn),
      .halt_req    (halt_req),
      .illegal_req (illegal_req),
      .reg_we      (reg_we),
      .halted      (halted),
      .illegal     (illegal)
   );

   fetch_unit u_fetch (
      .clk      (clk),
      .rst_n    (rst_n),
      .fif      (fif.fetch),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_adr   (wb_adr),
      .wb_rdata (wb_rdata),
      .wb_ack   (wb_ack)
   );

   insn_decoder u_dec (
      .insn    (insn),
      .op      (op),
      .rd      (rd),
      .rs1     (rs1),
      .rs2     (rs2),
      .imm     (imm),
      .use_imm (use_imm),
      .halt    (halt_req),
      .illegal (illegal_req)
   );

   reg_file u_rf (
      .clk      (clk),
      .rst_n    (rst_n),
      .we       (reg_we),
      .waddr    (rd),
      .wdata    (result),
      .raddr_a  (rs1),
      .rdata_a  (rdata_a),
      .raddr_b  (rs2),
      .rdata_b  (rdata_b),
      .dbg_addr (dbg_addr),
      .dbg_data (dbg_data)
   );

   // immediate forms and lui take b from the decoder
   assign opb = use_imm ? imm : rdata_b;

   bmu_alu u_alu (
      .op     (op),
      .a      (rdata_a),
      .b      (opb),
      .result (result)
   );

endmodule

/* hdl/bmu_pkg.sv */
package bmu_pkg;

   // datapath and memory line widths
   localparam int xlen       = 32;
   localparam int line_w     = 128;
   localparam int nregs      = 32;
   // byte offset bits inside one line, 16 bytes per line
   localparam int line_off_w = $clog2(line_w / 8);
   localparam int line_adr_w = xlen - line_off_w;

   typedef logic [xlen-1:0]            word_t;
   typedef logic [line_w-1:0]          line_t;
   typedef logic [$clog2(nregs)-1:0]   reg_idx_t;
   typedef logic [xlen-1:0]            pc_t;

   // alu operations
   typedef enum logic [4:0] {
      op_add, op_sub, op_xor, op_or, op_and,
      op_sll, op_srl, op_sra, op_lui,
      op_andn, op_orn, op_xnor,
      op_clz, op_ctz, op_cpop,
      op_sext_b, op_sext_h, op_zext_h,
      op_rol, op_ror, op_rev8, op_orc_b,
      op_bclr, op_bset, op_binv, op_bext,
      op_sh1add, op_sh2add, op_sh3add
   } bmu_op_e;

   typedef enum logic [1:0] {
      st_fetch,
      st_exec,
      st_halt
   } ctrl_state_e;

   // major opcodes
   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_lui    = 7'b0110111;

   // instruction field lsb positions
   localparam int rd_lsb  = 7;
   localparam int f3_lsb  = 12;
   localparam int rs1_lsb = 15;
   localparam int rs2_lsb = 20;
   localparam int f7_lsb  = 25;

   localparam word_t ebreak_insn = 32'h0010_0073;

endpackage

/* hdl/core_ctrl.sv */
module core_ctrl import bmu_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   fetch_if.ctrl fif,
   output word_t insn,
   input  logic  halt_req,
   input  logic  illegal_req,
   output logic  reg_we,
   output logic  halted,
   output logic  illegal
);

   ctrl_state_e state;
   pc_t         pc;
   word_t       insn_q;

   // request held for the whole fetch state, pc stable meanwhile
   assign fif.req = (state == st_fetch);
   assign fif.pc  = pc;
   assign insn    = insn_q;
   // halting instructions never write back
   assign reg_we  = (state == st_exec) && !halt_req;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= st_fetch;
         pc      <= '0;
         halted  <= 1'b0;
         illegal <= 1'b0;
      end else begin
         case (state)
            st_fetch: begin
               if (fif.ack) state <= st_exec;
            end
            st_exec: begin
               if (halt_req) begin
                  state   <= st_halt;
                  halted  <= 1'b1;
                  illegal <= illegal_req;
               end else begin
                  pc    <= pc + pc_t'(4);
                  state <= st_fetch;
               end
            end
            // final until reset
            default: state <= st_halt;
         endcase
      end
   end

   // instruction held for the decoder through st_exec
   always_ff @(posedge clk) begin
      if (state == st_fetch && fif.ack) insn_q <= fif.insn;
   end

endmodule

/* hdl/fetch_if.sv */
interface fetch_if import bmu_pkg::*; ();

   // request from the controller, held until ack
   logic  req;
   pc_t   pc;
   // one cycle pulse, insn valid with it
   logic  ack;
   word_t insn;

   modport ctrl (
      output req,
      output pc,
      input  ack,
      input  insn
   );

   modport fetch (
      input  req,
      input  pc,
      output ack,
      output insn
   );

endinterface

/* hdl/fetch_unit.sv */
module fetch_unit import bmu_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   fetch_if.fetch                fif,
   output logic                  wb_cyc,
   output logic                  wb_stb,
   output logic [line_adr_w-1:0] wb_adr,
   input  line_t                 wb_rdata,
   input  logic                  wb_ack
);

   line_t                 line_q;
   logic [line_adr_w-1:0] tag_q;
   logic                  line_vld;
   logic                  ack_q;
   word_t                 insn_q;
   logic [line_adr_w-1:0] req_line;
   logic                  pend;
   logic                  hit;
   logic                  capture;

   // word slot by pc[3:2], lowest address in the low word
   function automatic word_t pick_word(line_t l, logic [1:0] sel);
      return l[sel*xlen +: xlen];
   endfunction

   assign req_line = fif.pc[xlen-1:line_off_w];
   // new request not yet answered and no bus cycle open
   assign pend     = fif.req && !ack_q && !wb_cyc;
   assign hit      = line_vld && (tag_q == req_line);
   assign capture  = wb_cyc && wb_ack;

   assign fif.ack  = ack_q;
   assign fif.insn = insn_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_cyc   <= 1'b0;
         wb_stb   <= 1'b0;
         line_vld <= 1'b0;
         ack_q    <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         if (capture) begin
            // line arrives, answer the waiting request next cycle
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            line_vld <= 1'b1;
            ack_q    <= 1'b1;
         end else if (pend && hit) begin
            ack_q <= 1'b1;
         end else if (pend) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         line_q <= wb_rdata;
         tag_q  <= wb_adr;
         insn_q <= pick_word(wb_rdata, fif.pc[3:2]);
      end else if (pend && hit) begin
         insn_q <= pick_word(line_q, fif.pc[3:2]);
      end
      // line index latched when the bus cycle opens
      if (pend && !hit) begin
         wb_adr <= req_line;
      end
   end

endmodule

/* hdl/insn_decoder.sv */
module insn_decoder import bmu_pkg::*; (
   input  word_t    insn,
   output bmu_op_e  op,
   output reg_idx_t rd,
   output reg_idx_t rs1,
   output reg_idx_t rs2,
   output word_t    imm,
   output logic     use_imm,
   output logic     halt,
   output logic     illegal
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       unsup;

   assign opcode = insn[6:0];
   assign funct3 = insn[f3_lsb +: 3];
   assign funct7 = insn[f7_lsb +: 7];
   assign rd     = insn[rd_lsb +: 5];
   assign rs1    = insn[rs1_lsb +: 5];
   assign rs2    = insn[rs2_lsb +: 5];

   always_comb begin
      op      = op_add;
      // i-type immediate, shift amounts sit in its low five bits
      imm     = {{20{insn[31]}}, insn[31:20]};
      use_imm = 1'b0;
      unsup   = 1'b0;
      case (opcode)
         opc_lui: begin
            op      = op_lui;
            imm     = {insn[31:12], 12'b0};
            use_imm = 1'b1;
         end
         opc_op_imm: begin
            use_imm = 1'b1;
            case (funct3)
               3'b000: op = op_add;
               3'b100: op = op_xor;
               3'b110: op = op_or;
               3'b111: op = op_and;
               3'b001: begin
                  case (funct7)
                     7'b0000000: op = op_sll;
                     7'b0010100: op = op_bset;
                     7'b0100100: op = op_bclr;
                     7'b0110100: op = op_binv;
                     // zbb unary ops, selected by the rs2 field
                     7'b0110000: begin
                        case (rs2)
                           5'd0:    op = op_clz;
                           5'd1:    op = op_ctz;
                           5'd2:    op = op_cpop;
                           5'd4:    op = op_sext_b;
                           5'd5:    op = op_sext_h;
                           default: unsup = 1'b1;
                        endcase
                     end
                     default: unsup = 1'b1;
                  endcase
               end
               3'b101: begin
                  case ({funct7, rs2}) inside
                     {7'b0000000, 5'b?????}: op = op_srl;
                     {7'b0100000, 5'b?????}: op = op_sra;
                     {7'b0110000, 5'b?????}: op = op_ror;
                     {7'b0100100, 5'b?????}: op = op_bext;
                     {7'b0010100, 5'b00111}: op = op_orc_b;
                     {7'b0110100, 5'b11000}: op = op_rev8;
                     default:                unsup = 1'b1;
                  endcase
               end
               // slti and sltiu
               default: unsup = 1'b1;
            endcase
         end
         opc_op: begin
            case ({funct7, funct3})
               {7'b0000000, 3'b000}: op = op_add;
               {7'b0000000, 3'b001}: op = op_sll;
               {7'b0000000, 3'b100}: op = op_xor;
               {7'b0000000, 3'b101}: op = op_srl;
               {7'b0000000, 3'b110}: op = op_or;
               {7'b0000000, 3'b111}: op = op_and;
               {7'b0100000, 3'b000}: op = op_sub;
               {7'b0100000, 3'b101}: op = op_sra;
               {7'b0100000, 3'b100}: op = op_xnor;
               {7'b0100000, 3'b110}: op = op_orn;
               {7'b0100000, 3'b111}: op = op_andn;
               {7'b0010000, 3'b010}: op = op_sh1add;
               {7'b0010000, 3'b100}: op = op_sh2add;
               {7'b0010000, 3'b110}: op = op_sh3add;
               {7'b0110000, 3'b001}: op = op_rol;
               {7'b0110000, 3'b101}: op = op_ror;
               {7'b0100100, 3'b001}: op = op_bclr;
               {7'b0100100, 3'b101}: op = op_bext;
               {7'b0010100, 3'b001}: op = op_bset;
               {7'b0110100, 3'b001}: op = op_binv;
               default:              unsup = 1'b1;
            endcase
            // zext.h lives in the op space with rs2 zero
            if (funct7 == 7'b0000100 && funct3 == 3'b100 && rs2 == 5'd0) begin
               op    = op_zext_h;
               unsup = 1'b0;
            end
         end
         default: unsup = (insn != ebreak_insn);
      endcase
      illegal = unsup;
      halt    = unsup || (insn == ebreak_insn);
   end

endmodule

/* hdl/reg_file.sv */
module reg_file import bmu_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     we,
   input  reg_idx_t waddr,
   input  word_t    wdata,
   input  reg_idx_t raddr_a,
   output word_t    rdata_a,
   input  reg_idx_t raddr_b,
   output word_t    rdata_b,
   input  reg_idx_t dbg_addr,
   output word_t    dbg_data
);

   word_t regs [nregs];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < nregs; i++) begin
            regs[i] <= '0;
         end
      end else if (we && waddr != '0) begin
         // x0 never written, stays zero from reset
         regs[waddr] <= wdata;
      end
   end

   // execute ports
   assign rdata_a  = regs[raddr_a];
   assign rdata_b  = regs[raddr_b];
   // debug port for the outside
   assign dbg_data = regs[dbg_addr];

endmodule

/* list.f */
hdl/bmu_pkg.sv
hdl/fetch_if.sv
hdl/fetch_unit.sv
hdl/insn_decoder.sv
hdl/reg_file.sv
hdl/bmu_alu.sv
hdl/core_ctrl.sv
hdl/bmu_core_top.sv
dv/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_top -f list.f -Mdir obj_dir > sim.log 2>&1 &&
   ./obj_dir/Vtb_top >> sim.log 2>&1
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
